/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_fft2d
BUILD_DIR ?= obj_dir
FILELIST  ?= vlog.f
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= all tests passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

/* logic/bin_serializer.sv */
`timescale 1ns/1ps
`include "fft2d_params.svh"

module bin_serializer (
  input  logic                                   clk,
  input  logic                                   rst_n_i,
  input  logic                                   col_valid_i, // tile from column lanes
  input  fft2d_types_pkg::cplx_col_t             col_bins_i [`FFT2D_N][`FFT2D_N],
  output logic                                   out_valid_o,
  output logic                                   out_last_o,
  output logic signed [fft2d_types_pkg::COL_W-1:0] out_re_o,
  output logic signed [fft2d_types_pkg::COL_W-1:0] out_im_o
);

  localparam int PW = $clog2(`FFT2D_N); // index width per axis

  fft2d_types_pkg::cplx_col_t tile_q [`FFT2D_N][`FFT2D_N]; // [lane v][elem u]
  frame_ctrl_pkg::bin_t       bin_q;  // u in upper bits, v in lower
  logic                       busy_q; // draining a tile
  logic [PW-1:0]              lane_sel, elem_sel;

  assign lane_sel = bin_q[PW-1:0];    // v
  assign elem_sel = bin_q[2*PW-1:PW]; // u

  always_ff @(posedge clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      busy_q <= 1'b0;
      bin_q  <= '0;
    end
    else if (col_valid_i)
    begin
      busy_q <= 1'b1; // restart even on the last bin
      bin_q  <= '0;
    end
    else if (busy_q)
    begin
      bin_q <= bin_q + 1'b1;
      if (bin_q == frame_ctrl_pkg::LAST_BIN)
        busy_q <= 1'b0; // tile drained
    end
  end

  always_ff @(posedge clk)
  begin
    if (col_valid_i)
      tile_q <= col_bins_i; // whole tile at once
  end

  assign out_valid_o = busy_q;
  assign out_last_o  = busy_q && (bin_q == frame_ctrl_pkg::LAST_BIN);
  assign out_re_o    = tile_q[lane_sel][elem_sel].re; // bin (u, v)
  assign out_im_o    = tile_q[lane_sel][elem_sel].im;

  // a new tile may only land once the previous one is on its last bin
  a_not_busy : assert property (@(posedge clk) disable iff (!rst_n_i)
    col_valid_i |-> (!busy_q || out_last_o));

endmodule

/* logic/corner_turn.sv */
`timescale 1ns/1ps
`include "fft2d_params.svh"

module corner_turn (
  input  logic                       clk,
  input  logic                       rst_n_i,
  input  logic                       row_valid_i, // one transformed row
  input  fft2d_types_pkg::cplx_row_t row_bins_i [`FFT2D_N],
  output logic                       col_valid_o, // whole tile ready
  output fft2d_types_pkg::cplx_row_t col_vec_o  [`FFT2D_N][`FFT2D_N] // [col][row]
);

  fft2d_types_pkg::cplx_row_t tile_q [`FFT2D_N][`FFT2D_N]; // [row][col]
  frame_ctrl_pkg::row_t       row_q;                       // next row slot

  // row counter and tile strobe
  always_ff @(posedge clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      row_q       <= '0;
      col_valid_o <= 1'b0;
    end
    else
    begin
      col_valid_o <= 1'b0;
      if (row_valid_i)
      begin
        row_q <= row_q + 1'b1; // wraps to row 0
        if (row_q == frame_ctrl_pkg::LAST_ROW)
        begin
          col_valid_o <= 1'b1; // fourth row stored
        end
      end
    end
  end

  // tile storage, written one row at a time
  always_ff @(posedge clk)
  begin
    if (row_valid_i)
    begin
      tile_q[row_q] <= row_bins_i;
    end
  end

  // read side is a plain transpose, column c is element c of each row
  always_comb
  begin
    for (int c = 0; c < `FFT2D_N; c++)
    begin
      for (int r = 0; r < `FFT2D_N; r++)
      begin
        col_vec_o[c][r] = tile_q[r][c];
      end
    end
  end

endmodule

/* logic/dft4_lane.sv */
`timescale 1ns/1ps
`include "fft2d_params.svh"

module dft4_lane #(
  parameter type in_t  = fft2d_types_pkg::cplx_in_t,
  parameter type out_t = fft2d_types_pkg::cplx_row_t
) (
  input  logic clk,
  input  logic rst_n_i,
  input  logic in_valid_i,
  input  in_t  in_vec_i [`FFT2D_N],
  output logic out_valid_o,
  output out_t out_vec_o [`FFT2D_N]
);

  localparam int OW = $bits(out_t) / 2; // output component width

  logic signed [OW-1:0] xr [`FFT2D_N]; // sign-extended inputs
  logic signed [OW-1:0] xi [`FFT2D_N];
  logic signed [OW-1:0] ar, ai, br, bi; // even pair sum and difference
  logic signed [OW-1:0] cr, ci, dr, di; // odd pair sum and difference

  // radix-4 butterfly, twiddles are only +-1 and +-j
  always_comb
  begin
    for (int n = 0; n < `FFT2D_N; n++)
    begin
      xr[n] = in_vec_i[n].re; // widen before adding
      xi[n] = in_vec_i[n].im;
    end
    ar = xr[0] + xr[2];
    ai = xi[0] + xi[2];
    br = xr[0] - xr[2];
    bi = xi[0] - xi[2];
    cr = xr[1] + xr[3];
    ci = xi[1] + xi[3];
    dr = xr[1] - xr[3];
    di = xi[1] - xi[3];
  end

  always_ff @(posedge clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
      out_valid_o <= 1'b0;
    else
      out_valid_o <= in_valid_i; // fixed one-cycle latency
  end

  always_ff @(posedge clk)
  begin
    if (in_valid_i)
    begin
      out_vec_o[0].re <= ar + cr; // dc term
      out_vec_o[0].im <= ai + ci;
      out_vec_o[1].re <= br + di; // b - j*d
      out_vec_o[1].im <= bi - dr;
      out_vec_o[2].re <= ar - cr; // alternating signs
      out_vec_o[2].im <= ai - ci;
      out_vec_o[3].re <= br - di; // b + j*d
      out_vec_o[3].im <= bi + dr;
    end
  end

  // downstream stages count on the exact one-cycle latency
  a_lat : assert property (@(posedge clk) disable iff (!rst_n_i)
    out_valid_o == $past(in_valid_i));

endmodule

/* logic/fft2d_params.svh */
`ifndef FFT2D_PARAMS_SVH
`define FFT2D_PARAMS_SVH

// tile side, also the point count of every 1D transform
// the butterfly in dft4_lane is written for 4 points only
`define FFT2D_N 4

// input component width, signed
`define FFT2D_IN_W 16

// growth per 4-point pass, log2 of the point count
`define FFT2D_GROW_W 2

`endif

/* logic/fft2d_top.sv */
`timescale 1ns/1ps
`include "fft2d_params.svh"

module fft2d_top (
  input  logic                                     clk,
  input  logic                                     rst_n_i,
  input  logic                                     in_valid_i,
  input  logic signed [`FFT2D_IN_W-1:0]            in_re_i,
  input  logic signed [`FFT2D_IN_W-1:0]            in_im_i,
  output logic                                     out_valid_o,
  output logic                                     out_last_o,
  output logic signed [fft2d_types_pkg::COL_W-1:0] out_re_o,
  output logic signed [fft2d_types_pkg::COL_W-1:0] out_im_o
);

  logic                       row_valid;      // loader to row lane
  fft2d_types_pkg::cplx_in_t  row_vec    [`FFT2D_N];
  logic                       row_bins_valid; // row lane to corner turn
  fft2d_types_pkg::cplx_row_t row_bins   [`FFT2D_N];
  logic                       col_valid;      // shared by all column lanes
  fft2d_types_pkg::cplx_row_t col_vec    [`FFT2D_N][`FFT2D_N];
  logic [`FFT2D_N-1:0]        col_bins_valid; // one per lane
  fft2d_types_pkg::cplx_col_t col_bins   [`FFT2D_N][`FFT2D_N];

  frame_loader u_loader (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .in_valid_i  (in_valid_i),
    .in_re_i     (in_re_i),
    .in_im_i     (in_im_i),
    .row_valid_o (row_valid),
    .row_vec_o   (row_vec)
  );

  dft4_lane #(
    .in_t  (fft2d_types_pkg::cplx_in_t),
    .out_t (fft2d_types_pkg::cplx_row_t)
  ) u_row_lane (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .in_valid_i  (row_valid),
    .in_vec_i    (row_vec),
    .out_valid_o (row_bins_valid),
    .out_vec_o   (row_bins)
  );

  corner_turn u_corner (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .row_valid_i (row_bins_valid),
    .row_bins_i  (row_bins),
    .col_valid_o (col_valid),
    .col_vec_o   (col_vec)
  );

  for (genvar c = 0; c < `FFT2D_N; c++)
  begin : g_col_lane
    dft4_lane #(
      .in_t  (fft2d_types_pkg::cplx_row_t),
      .out_t (fft2d_types_pkg::cplx_col_t)
    ) u_col_lane (
      .clk         (clk),
      .rst_n_i     (rst_n_i),
      .in_valid_i  (col_valid),
      .in_vec_i    (col_vec[c]),
      .out_valid_o (col_bins_valid[c]),
      .out_vec_o   (col_bins[c])
    );
  end

  bin_serializer u_serializer (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .col_valid_i (col_bins_valid[0]), // lane 0 speaks for all
    .col_bins_i  (col_bins),
    .out_valid_o (out_valid_o),
    .out_last_o  (out_last_o),
    .out_re_o    (out_re_o),
    .out_im_o    (out_im_o)
  );

  // column lanes run in lockstep, so the serializer may trust lane 0
  a_lanes_agree : assert property (@(posedge clk) disable iff (!rst_n_i)
    (col_bins_valid == '0) || (&col_bins_valid));

endmodule

/* logic/fft2d_types_pkg.sv */
`include "fft2d_params.svh"

package fft2d_types_pkg;

  localparam int ROW_W = `FFT2D_IN_W + `FFT2D_GROW_W;     // after row pass
  localparam int COL_W = `FFT2D_IN_W + 2 * `FFT2D_GROW_W; // after column pass

  // raw input sample
  typedef struct packed {
    logic signed [`FFT2D_IN_W-1:0] re;
    logic signed [`FFT2D_IN_W-1:0] im;
  } cplx_in_t;

  // row transform result
  typedef struct packed {
    logic signed [ROW_W-1:0] re;
    logic signed [ROW_W-1:0] im;
  } cplx_row_t;

  // final 2D bin
  typedef struct packed {
    logic signed [COL_W-1:0] re;
    logic signed [COL_W-1:0] im;
  } cplx_col_t;

endpackage

/* logic/frame_ctrl_pkg.sv */
`include "fft2d_params.svh"

package frame_ctrl_pkg;

  typedef logic [$clog2(`FFT2D_N)-1:0]           pos_t; // slot within a row
  typedef logic [$clog2(`FFT2D_N)-1:0]           row_t; // row in the tile
  typedef logic [$clog2(`FFT2D_N*`FFT2D_N)-1:0] bin_t; // bin in the tile

  localparam pos_t LAST_POS = pos_t'(`FFT2D_N - 1);
  localparam row_t LAST_ROW = row_t'(`FFT2D_N - 1);
  localparam bin_t LAST_BIN = bin_t'(`FFT2D_N * `FFT2D_N - 1);

endpackage

/* logic/frame_loader.sv */
`timescale 1ns/1ps
`include "fft2d_params.svh"

module frame_loader (
  input  logic                          clk,
  input  logic                          rst_n_i,
  input  logic                          in_valid_i,  // one sample per strobe
  input  logic signed [`FFT2D_IN_W-1:0] in_re_i,
  input  logic signed [`FFT2D_IN_W-1:0] in_im_i,
  output logic                          row_valid_o, // full row ready
  output fft2d_types_pkg::cplx_in_t     row_vec_o [`FFT2D_N]
);

  frame_ctrl_pkg::pos_t pos_q; // next free slot

  // position counter and row strobe
  always_ff @(posedge clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      pos_q       <= '0;  // partial row dropped
      row_valid_o <= 1'b0;
    end
    else
    begin
      row_valid_o <= 1'b0;
      if (in_valid_i)
      begin
        pos_q <= pos_q + 1'b1; // wraps after last slot
        if (pos_q == frame_ctrl_pkg::LAST_POS)
        begin
          row_valid_o <= 1'b1; // row complete
        end
      end
    end
  end

  // sample payload, held until overwritten by the next row
  always_ff @(posedge clk)
  begin
    if (in_valid_i)
    begin
      row_vec_o[pos_q].re <= in_re_i;
      row_vec_o[pos_q].im <= in_im_i;
    end
  end

endmodule

/* testbench/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int PERIOD_NS  = 4,
  parameter int RST_CYCLES = 3
) (
  input  logic rst_req_i, // extra reset pulse from the test sequence
  output logic clk,
  output logic rst_n_o
);

  logic por_n; // power-on reset, low for the first cycles

  initial
  begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  initial
  begin
    por_n = 1'b0;
    repeat (RST_CYCLES) @(posedge clk);
    por_n <= 1'b1; // release just after an edge
  end

  assign rst_n_o = por_n && !rst_req_i;

endmodule

/* testbench/tb_fft2d.sv */
`timescale 1ns/1ps
`include "fft2d_params.svh"

module tb_fft2d;

  localparam int SEED    = 99724;
  localparam int NPIX    = `FFT2D_N * `FFT2D_N; // bins per tile
  localparam int TIMEOUT = 200;                 // cycles per wait
  localparam int CW      = fft2d_types_pkg::COL_W;
  localparam int TW_RE [4] = '{1, 0, -1, 0};    // (-j)^p, real part
  localparam int TW_IM [4] = '{0, -1, 0, 1};    // (-j)^p, imaginary part

  logic                          clk, rst_n, rst_req;
  logic                          in_valid;
  logic signed [`FFT2D_IN_W-1:0] in_re, in_im;
  logic                          out_valid, out_last;
  logic signed [CW-1:0]          out_re, out_im;

  fft2d_types_pkg::cplx_in_t frame [NPIX]; // row-major tile being sent
  longint exp_re [$], exp_im [$];          // model bins in output order
  longint got_re [$], got_im [$];
  bit     got_last [$];
  int     lat_q [$];                       // last accepted sample to first bin
  int     cycle = 0, last_acc = 0;
  int     errs, total_errs = 0, n_tests = 0, n_fail = 0;
  logic   prev_valid = 1'b0;

  tb_clock_gen u_clk_gen (.rst_req_i(rst_req), .clk(clk), .rst_n_o(rst_n));

  fft2d_top DUT (
    .clk         (clk),
    .rst_n_i     (rst_n),
    .in_valid_i  (in_valid),
    .in_re_i     (in_re),
    .in_im_i     (in_im),
    .out_valid_o (out_valid),
    .out_last_o  (out_last),
    .out_re_o    (out_re),
    .out_im_o    (out_im)
  );

  // monitor, sees pre-edge values
  always @(posedge clk)
  begin
    cycle++;
    if (in_valid)
      last_acc = cycle; // edge that accepts a sample
    if (out_valid && !prev_valid)
      lat_q.push_back(cycle - last_acc);
    if (out_valid)
    begin
      got_re.push_back(out_re);
      got_im.push_back(out_im);
      got_last.push_back(out_last);
    end
    prev_valid = out_valid;
  end

  task automatic random_frame();
    logic [31:0] r;
    for (int i = 0; i < NPIX; i++)
    begin
      r = $urandom;
      frame[i] = r; // re in upper half
    end
  endtask

  task automatic constant_frame(input logic signed [`FFT2D_IN_W-1:0] val);
    for (int i = 0; i < NPIX; i++)
    begin
      frame[i].re = val;
      frame[i].im = val;
    end
  endtask

  // direct 2D DFT, bin (u, v) = sum x[m][n] * (-j)^(um + vn)
  function automatic void model_frame();
    longint a, b, sr, si;
    int     p;
    for (int u = 0; u < `FFT2D_N; u++)
      for (int v = 0; v < `FFT2D_N; v++)
      begin
        sr = 0;
        si = 0;
        for (int m = 0; m < `FFT2D_N; m++)
          for (int n = 0; n < `FFT2D_N; n++)
          begin
            a  = frame[m * `FFT2D_N + n].re;
            b  = frame[m * `FFT2D_N + n].im;
            p  = (u * m + v * n) % 4;
            sr += a * TW_RE[p] - b * TW_IM[p];
            si += a * TW_IM[p] + b * TW_RE[p];
          end
        exp_re.push_back(sr);
        exp_im.push_back(si);
      end
  endfunction

  task automatic drive_frame(input int max_gap, input int count);
    int gap;
    for (int i = 0; i < count; i++)
    begin
      gap = (max_gap > 0) ? int'($urandom_range(max_gap, 0)) : 0;
      repeat (gap)
      begin
        @(posedge clk);
        in_valid <= 1'b0; // idle slot
      end
      @(posedge clk);
      in_valid <= 1'b1;
      in_re    <= frame[i].re;
      in_im    <= frame[i].im;
    end
  endtask

  task automatic go_idle();
    @(posedge clk);
    in_valid <= 1'b0;
  endtask

  task automatic await_reset();
    for (int t = 0; t < TIMEOUT && !rst_n; t++)
      @(posedge clk);
    if (!rst_n)
    begin
      $display("reset never released within %0d cycles", TIMEOUT);
      $display("tests failed");
      $finish;
    end
  endtask

  task automatic collect_bins(input string name);
    for (int t = 0; t < TIMEOUT && got_re.size() < exp_re.size(); t++)
      @(posedge clk);
    if (got_re.size() < exp_re.size())
    begin
      $display("%s: only %0d of %0d bins arrived within %0d cycles", name,
               got_re.size(), exp_re.size(), TIMEOUT);
      $display("tests failed");
      $finish;
    end
  endtask

  task automatic compare_bins(input string name);
    assert (got_re.size() == exp_re.size()) else
    begin
      $display("%s: got %0d bins, wanted %0d", name, got_re.size(), exp_re.size());
      errs++;
    end
    for (int i = 0; i < exp_re.size() && i < got_re.size(); i++)
    begin
      assert (got_re[i] == exp_re[i] && got_im[i] == exp_im[i]) else
      begin
        $display("MISMATCH %s bin %0d: expected (%0d, %0d) actual (%0d, %0d)", name, i,
                 exp_re[i], exp_im[i], got_re[i], got_im[i]);
        errs++;
      end
      assert (got_last[i] == (i % NPIX == NPIX - 1)) else
      begin
        $display("MISMATCH %s last flag bin %0d: expected %0d actual %0d", name, i,
                 (i % NPIX == NPIX - 1), got_last[i]);
        errs++;
      end
    end
  endtask

  task automatic begin_test();
    errs = 0;
    exp_re.delete();
    exp_im.delete();
    got_re.delete();
    got_im.delete();
    got_last.delete();
    lat_q.delete();
  endtask

  task automatic end_test(input string name);
    n_tests++;
    total_errs += errs;
    if (errs != 0)
      n_fail++;
    $display("test %-10s %s", name, (errs == 0) ? "ok" : "FAILED");
  endtask

  task automatic send_and_check(input string name, input int frames, input int max_gap);
    for (int f = 0; f < frames; f++)
    begin
      random_frame();
      model_frame();
      drive_frame(max_gap, NPIX);
      go_idle();
      collect_bins(name); // one tile at a time
    end
  endtask

  initial
  begin
    void'($urandom(SEED));
    in_valid = 1'b0;
    in_re    = '0;
    in_im    = '0;
    rst_req  = 1'b0;
    await_reset();

    begin_test(); // continuous random frames
    send_and_check("random", 4, 0);
    compare_bins("random");
    end_test("random");

    begin_test(); // full-scale tiles, only the dc bin is nonzero
    constant_frame(16'sd32767);
    for (int i = 0; i < NPIX; i++)
    begin
      exp_re.push_back((i == 0) ? longint'(NPIX) * 32767 : 0);
      exp_im.push_back((i == 0) ? longint'(NPIX) * 32767 : 0);
    end
    drive_frame(0, NPIX);
    go_idle();
    collect_bins("extreme");
    constant_frame(-16'sd32768);
    for (int i = 0; i < NPIX; i++)
    begin
      exp_re.push_back((i == 0) ? longint'(NPIX) * -32768 : 0);
      exp_im.push_back((i == 0) ? longint'(NPIX) * -32768 : 0);
    end
    drive_frame(0, NPIX);
    go_idle();
    collect_bins("extreme");
    compare_bins("extreme");
    end_test("extreme");

    begin_test(); // no idle cycle between tiles
    for (int f = 0; f < 5; f++)
    begin
      random_frame();
      model_frame();
      drive_frame(0, NPIX); // frame array is reused only after it was sent
    end
    go_idle();
    collect_bins("burst");
    compare_bins("burst");
    end_test("burst");

    begin_test(); // random input gaps
    send_and_check("gaps", 4, 3);
    compare_bins("gaps");
    assert (lat_q.size() == 4) else
    begin
      $display("gaps: saw %0d output bursts instead of 4", lat_q.size());
      errs++;
    end
    foreach (lat_q[i])
      assert (lat_q[i] == 5) else
      begin
        $display("MISMATCH gaps latency frame %0d: expected 5 actual %0d", i, lat_q[i]);
        errs++;
      end
    end_test("gaps");

    begin_test(); // reset in the middle of a tile
    random_frame();
    drive_frame(0, NPIX); // whole tile still in the pipeline
    drive_frame(0, 3);    // start of the next tile
    @(posedge clk);
    in_valid <= 1'b0;
    rst_req  <= 1'b1;
    repeat (3) @(posedge clk);
    rst_req <= 1'b0;
    repeat (24) @(posedge clk); // quiet window after release
    assert (got_re.size() == 0) else
    begin
      $display("reset: %0d bins came out of a discarded tile", got_re.size());
      errs++;
    end
    send_and_check("reset", 1, 0);
    compare_bins("reset");
    end_test("reset");

    $display("%0d run, %0d ok, %0d bad, %0d check errors", n_tests, n_tests - n_fail,
             n_fail, total_errs);
    if (n_fail == 0)
      $display("all tests passed");
    else
      $display("tests failed");
    $finish;
  end

endmodule

/* vlog.f */
+incdir+logic
logic/fft2d_types_pkg.sv
logic/frame_ctrl_pkg.sv
logic/frame_loader.sv
logic/dft4_lane.sv
logic/corner_turn.sv
logic/bin_serializer.sv
logic/fft2d_top.sv
testbench/tb_clock_gen.sv
testbench/tb_fft2d.sv
